/* source/mips_settings.svh */
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// Word width of registers, bus and datapath
`define MIPS_DATA_WIDTH 32

// General purpose registers
`define MIPS_REG_COUNT 32

// Boot address and the address that stops the core
`define MIPS_RESET_VECTOR 32'hBFC0_0000
`define MIPS_HALT_ADDRESS 32'h0000_0000

`endif

/* source/mips_pkg.sv */
package mips_pkg;

    // Primary opcodes, instr[31:26]
    typedef enum logic [5:0] {
        OPCODE_R_TYPE = 6'h00,
        OPCODE_J      = 6'h02,
        OPCODE_BEQ    = 6'h04,
        OPCODE_BNE    = 6'h05,
        OPCODE_ADDIU  = 6'h09,
        OPCODE_SLTI   = 6'h0A,
        OPCODE_ANDI   = 6'h0C,
        OPCODE_ORI    = 6'h0D,
        OPCODE_XORI   = 6'h0E,
        OPCODE_LUI    = 6'h0F,
        OPCODE_LB     = 6'h20,
        OPCODE_LH     = 6'h21,
        OPCODE_LW     = 6'h23,
        OPCODE_LBU    = 6'h24,
        OPCODE_LHU    = 6'h25,
        OPCODE_SW     = 6'h2B
    } opcode_t;

    // R-type function field, instr[5:0]
    typedef enum logic [5:0] {
        FUNCTION_SLL  = 6'h00,
        FUNCTION_SRL  = 6'h02,
        FUNCTION_SRA  = 6'h03,
        FUNCTION_JR   = 6'h08,
        FUNCTION_ADDU = 6'h21,
        FUNCTION_SUBU = 6'h23,
        FUNCTION_AND  = 6'h24,
        FUNCTION_OR   = 6'h25,
        FUNCTION_XOR  = 6'h26,
        FUNCTION_SLT  = 6'h2A,
        FUNCTION_SLTU = 6'h2B
    } function_t;

    // Instruction sequencing
    typedef enum logic [1:0] {
        FETCH,
        EXEC,
        MEM_ACCESS,
        HALTED
    } state_t;

endpackage

/* source/mips_exec_if.sv */
`include "mips_settings.svh"

interface mips_exec_if;
    import mips_pkg::*;

    opcode_t                     opcode;
    function_t                   funct;
    logic [4:0]                  shamt;
    // Low 26 instruction bits
    // The immediate is imm[15:0] and the jump index uses all of them
    logic [25:0]                 imm;
    logic [`MIPS_DATA_WIDTH-1:0] rs_value;
    logic [`MIPS_DATA_WIDTH-1:0] rt_value;
    logic [`MIPS_DATA_WIDTH-1:0] pc_plus4;

    modport control (
        output opcode, funct, shamt, imm, rs_value, rt_value, pc_plus4
    );

    modport unit (
        input opcode, funct, shamt, imm, rs_value, rt_value, pc_plus4
    );

endinterface

/* source/mips_register_file.sv */
`include "mips_settings.svh"

module mips_register_file (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [4:0]                  read_addr_a,
    input  logic [4:0]                  read_addr_b,
    output logic [`MIPS_DATA_WIDTH-1:0] read_data_a,
    output logic [`MIPS_DATA_WIDTH-1:0] read_data_b,
    input  logic                        write_enable,
    input  logic [4:0]                  write_addr,
    input  logic [`MIPS_DATA_WIDTH-1:0] write_data,
    output logic [`MIPS_DATA_WIDTH-1:0] v0
);

    logic [`MIPS_DATA_WIDTH-1:0] regs [`MIPS_REG_COUNT];

    // Register zero is never written so it keeps its reset value
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && write_addr != 5'd0) begin
            regs[write_addr] <= write_data;
        end
    end

    // Asynchronous read ports
    assign read_data_a = regs[read_addr_a];
    assign read_data_b = regs[read_addr_b];

    // $v0 for the top level
    assign v0 = regs[2];

endmodule

/* source/mips_alu.sv */
`include "mips_settings.svh"

module mips_alu (
    mips_exec_if.unit                   exec,
    output logic [`MIPS_DATA_WIDTH-1:0] alu_result,
    output logic                        alu_writes,
    output logic                        branch_taken,
    output logic [`MIPS_DATA_WIDTH-1:0] branch_target
);
    import mips_pkg::*;

    logic [`MIPS_DATA_WIDTH-1:0] imm_sext;
    logic [`MIPS_DATA_WIDTH-1:0] imm_zext;
    logic [`MIPS_DATA_WIDTH-1:0] rs;
    logic [`MIPS_DATA_WIDTH-1:0] rt;
    logic                        less_signed;
    logic                        less_unsigned;
    logic                        less_imm;

    assign rs       = exec.rs_value;
    assign rt       = exec.rt_value;
    assign imm_sext = {{16{exec.imm[15]}}, exec.imm[15:0]};
    assign imm_zext = {16'h0000, exec.imm[15:0]};

    // Compares used by SLT, SLTU and SLTI
    assign less_signed   = $signed(rs) < $signed(rt);
    assign less_unsigned = rs < rt;
    assign less_imm      = $signed(rs) < $signed(imm_sext);

    always_comb begin
        alu_result    = '0;
        alu_writes    = 1'b0;
        branch_taken  = 1'b0;
        // PC relative target unless a jump replaces it below
        branch_target = exec.pc_plus4 + (imm_sext << 2);

        case (exec.opcode)
            OPCODE_R_TYPE: begin
                alu_writes = 1'b1;
                case (exec.funct)
                    FUNCTION_ADDU: alu_result = rs + rt;
                    FUNCTION_SUBU: alu_result = rs - rt;
                    FUNCTION_AND:  alu_result = rs & rt;
                    FUNCTION_OR:   alu_result = rs | rt;
                    FUNCTION_XOR:  alu_result = rs ^ rt;
                    FUNCTION_SLT:  alu_result = {{(`MIPS_DATA_WIDTH-1){1'b0}}, less_signed};
                    FUNCTION_SLTU: alu_result = {{(`MIPS_DATA_WIDTH-1){1'b0}}, less_unsigned};
                    // Shifts act on rt by the shamt field
                    FUNCTION_SLL:  alu_result = rt << exec.shamt;
                    FUNCTION_SRL:  alu_result = rt >> exec.shamt;
                    FUNCTION_SRA:  alu_result = $signed(rt) >>> exec.shamt;
                    FUNCTION_JR: begin
                        alu_writes    = 1'b0;
                        branch_taken  = 1'b1;
                        branch_target = rs;
                    end
                    default:       alu_writes = 1'b0;
                endcase
            end
            OPCODE_ADDIU: begin
                alu_writes = 1'b1;
                alu_result = rs + imm_sext;
            end
            OPCODE_SLTI: begin
                alu_writes = 1'b1;
                alu_result = {{(`MIPS_DATA_WIDTH-1){1'b0}}, less_imm};
            end
            OPCODE_ANDI: begin
                alu_writes = 1'b1;
                alu_result = rs & imm_zext;
            end
            OPCODE_ORI: begin
                alu_writes = 1'b1;
                alu_result = rs | imm_zext;
            end
            OPCODE_XORI: begin
                alu_writes = 1'b1;
                alu_result = rs ^ imm_zext;
            end
            OPCODE_LUI: begin
                alu_writes = 1'b1;
                alu_result = {exec.imm[15:0], 16'h0000};
            end
            OPCODE_BEQ: branch_taken = (rs == rt);
            OPCODE_BNE: branch_taken = (rs != rt);
            OPCODE_J: begin
                branch_taken  = 1'b1;
                branch_target = {exec.pc_plus4[31:28], exec.imm, 2'b00};
            end
            default: ;
        endcase
    end

endmodule

/* source/mips_load_store.sv */
`include "mips_settings.svh"

module mips_load_store (
    mips_exec_if.unit                   exec,
    input  logic [`MIPS_DATA_WIDTH-1:0] readdata,
    output logic [`MIPS_DATA_WIDTH-1:0] data_address,
    output logic [3:0]                  data_byteenable,
    output logic [`MIPS_DATA_WIDTH-1:0] data_writedata,
    output logic                        is_load,
    output logic                        is_store,
    output logic [`MIPS_DATA_WIDTH-1:0] load_value
);
    import mips_pkg::*;

    logic [`MIPS_DATA_WIDTH-1:0] effective;
    logic [1:0]                  lane;
    logic [7:0]                  load_byte;
    logic [15:0]                 load_half;

    // Base register plus signed offset
    assign effective    = exec.rs_value + {{16{exec.imm[15]}}, exec.imm[15:0]};
    assign lane         = effective[1:0];
    assign data_address = {effective[31:2], 2'b00};

    // Only SW stores, always the whole word
    assign data_writedata = exec.rt_value;

    // Pick the addressed lanes out of the returned word
    always_comb begin
        case (lane)
            2'd0:    load_byte = readdata[7:0];
            2'd1:    load_byte = readdata[15:8];
            2'd2:    load_byte = readdata[23:16];
            default: load_byte = readdata[31:24];
        endcase
    end

    assign load_half = lane[1] ? readdata[31:16] : readdata[15:0];

    always_comb begin
        is_load         = 1'b1;
        is_store        = 1'b0;
        data_byteenable = 4'b0000;
        load_value      = readdata;

        case (exec.opcode)
            OPCODE_LB: begin
                data_byteenable = 4'b0001 << lane;
                load_value      = {{24{load_byte[7]}}, load_byte};
            end
            OPCODE_LBU: begin
                data_byteenable = 4'b0001 << lane;
                load_value      = {24'h000000, load_byte};
            end
            OPCODE_LH: begin
                data_byteenable = lane[1] ? 4'b1100 : 4'b0011;
                load_value      = {{16{load_half[15]}}, load_half};
            end
            OPCODE_LHU: begin
                data_byteenable = lane[1] ? 4'b1100 : 4'b0011;
                load_value      = {16'h0000, load_half};
            end
            OPCODE_LW: begin
                data_byteenable = 4'b1111;
            end
            OPCODE_SW: begin
                is_load         = 1'b0;
                is_store        = 1'b1;
                data_byteenable = 4'b1111;
            end
            // Not a memory instruction
            default: begin
                is_load = 1'b0;
            end
        endcase
    end

endmodule

/* source/mips_core_control.sv */
`include "mips_settings.svh"

module mips_core_control (
    input  logic                        clk,
    input  logic                        reset,
    output logic                        active,
    output logic [`MIPS_DATA_WIDTH-1:0] address,
    output logic                        read,
    output logic                        write,
    input  logic                        waitrequest,
    output logic [`MIPS_DATA_WIDTH-1:0] writedata,
    output logic [3:0]                  byteenable,
    input  logic [`MIPS_DATA_WIDTH-1:0] readdata,
    mips_exec_if.control                exec,
    output logic [4:0]                  rf_read_addr_a,
    output logic [4:0]                  rf_read_addr_b,
    input  logic [`MIPS_DATA_WIDTH-1:0] rf_read_data_a,
    input  logic [`MIPS_DATA_WIDTH-1:0] rf_read_data_b,
    output logic                        rf_write_enable,
    output logic [4:0]                  rf_write_addr,
    output logic [`MIPS_DATA_WIDTH-1:0] rf_write_data,
    input  logic [`MIPS_DATA_WIDTH-1:0] alu_result,
    input  logic                        alu_writes,
    input  logic                        branch_taken,
    input  logic [`MIPS_DATA_WIDTH-1:0] branch_target,
    input  logic [`MIPS_DATA_WIDTH-1:0] data_address,
    input  logic [3:0]                  data_byteenable,
    input  logic [`MIPS_DATA_WIDTH-1:0] data_writedata,
    input  logic                        is_load,
    input  logic                        is_store,
    input  logic [`MIPS_DATA_WIDTH-1:0] load_value
);
    import mips_pkg::*;

    state_t                      state;
    logic [`MIPS_DATA_WIDTH-1:0] pc;
    logic [`MIPS_DATA_WIDTH-1:0] ir;
    logic [`MIPS_DATA_WIDTH-1:0] delay_target;
    logic                        delay_pending;
    opcode_t                     opcode;
    logic                        at_halt;
    logic                        instr_done;

    assign opcode  = opcode_t'(ir[31:26]);
    assign at_halt = (pc == `MIPS_HALT_ADDRESS);

    // Decoded fields stay put until the next fetch completes
    assign exec.opcode   = opcode;
    assign exec.funct    = function_t'(ir[5:0]);
    assign exec.shamt    = ir[10:6];
    assign exec.imm      = ir[25:0];
    assign exec.rs_value = rf_read_data_a;
    assign exec.rt_value = rf_read_data_b;
    assign exec.pc_plus4 = pc + 4;

    assign rf_read_addr_a = ir[25:21];
    assign rf_read_addr_b = ir[20:16];

    // Last cycle of the current instruction
    assign instr_done = (state == EXEC && !is_load && !is_store) ||
                        (state == MEM_ACCESS && !waitrequest);

    // Write-back goes to rd for R-type and to rt otherwise
    assign rf_write_enable = (state == EXEC && alu_writes) ||
                             (state == MEM_ACCESS && is_load && !waitrequest);
    assign rf_write_addr   = (opcode == OPCODE_R_TYPE) ? ir[15:11] : ir[20:16];
    assign rf_write_data   = (state == MEM_ACCESS) ? load_value : alu_result;

    // Bus shared by instruction fetch and data access and idle in reset
    assign read       = !reset && ((state == FETCH && !at_halt) ||
                                   (state == MEM_ACCESS && is_load));
    assign write      = !reset && state == MEM_ACCESS && is_store;
    assign address    = (state == MEM_ACCESS) ? data_address : pc;
    assign byteenable = (state == MEM_ACCESS) ? data_byteenable : 4'b1111;
    assign writedata  = data_writedata;

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= FETCH;
            active        <= 1'b1;
            pc            <= `MIPS_RESET_VECTOR;
            delay_pending <= 1'b0;
        end else begin
            case (state)
                FETCH: begin
                    if (at_halt) begin
                        state  <= HALTED;
                        active <= 1'b0;
                    end else if (!waitrequest) begin
                        state <= EXEC;
                    end
                end
                EXEC:       state <= (is_load || is_store) ? MEM_ACCESS : FETCH;
                MEM_ACCESS: state <= waitrequest ? MEM_ACCESS : FETCH;
                default:    state <= HALTED;
            endcase

            // The delay slot runs before the recorded target is taken
            if (instr_done) begin
                pc            <= delay_pending ? delay_target : pc + 4;
                delay_pending <= branch_taken;
            end
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (state == FETCH && !waitrequest) begin
            ir <= readdata;
        end
        if (instr_done) begin
            delay_target <= branch_target;
        end
    end

endmodule

/* source/mips_cpu_bus.sv */
`include "mips_settings.svh"

module mips_cpu_bus (
    input  logic                        clk,
    input  logic                        reset,
    output logic                        active,
    output logic [`MIPS_DATA_WIDTH-1:0] register_v0,
    output logic [`MIPS_DATA_WIDTH-1:0] address,
    output logic                        read,
    output logic                        write,
    input  logic                        waitrequest,
    output logic [`MIPS_DATA_WIDTH-1:0] writedata,
    output logic [3:0]                  byteenable,
    input  logic [`MIPS_DATA_WIDTH-1:0] readdata
);

    logic [4:0]                  rf_read_addr_a;
    logic [4:0]                  rf_read_addr_b;
    logic [`MIPS_DATA_WIDTH-1:0] rf_read_data_a;
    logic [`MIPS_DATA_WIDTH-1:0] rf_read_data_b;
    logic                        rf_write_enable;
    logic [4:0]                  rf_write_addr;
    logic [`MIPS_DATA_WIDTH-1:0] rf_write_data;
    logic [`MIPS_DATA_WIDTH-1:0] alu_result;
    logic                        alu_writes;
    logic                        branch_taken;
    logic [`MIPS_DATA_WIDTH-1:0] branch_target;
    logic [`MIPS_DATA_WIDTH-1:0] data_address;
    logic [3:0]                  data_byteenable;
    logic [`MIPS_DATA_WIDTH-1:0] data_writedata;
    logic                        is_load;
    logic                        is_store;
    logic [`MIPS_DATA_WIDTH-1:0] load_value;

    // Decoded operands shared by the ALU and the load/store unit
    mips_exec_if exec_bus ();

    mips_core_control core_control_i (
        .clk, .reset, .active, .address, .read, .write, .waitrequest,
        .writedata, .byteenable, .readdata,
        .exec (exec_bus.control),
        .rf_read_addr_a, .rf_read_addr_b, .rf_read_data_a, .rf_read_data_b,
        .rf_write_enable, .rf_write_addr, .rf_write_data,
        .alu_result, .alu_writes, .branch_taken, .branch_target,
        .data_address, .data_byteenable, .data_writedata,
        .is_load, .is_store, .load_value
    );

    mips_register_file register_file_i (
        .clk, .reset,
        .read_addr_a  (rf_read_addr_a),
        .read_addr_b  (rf_read_addr_b),
        .read_data_a  (rf_read_data_a),
        .read_data_b  (rf_read_data_b),
        .write_enable (rf_write_enable),
        .write_addr   (rf_write_addr),
        .write_data   (rf_write_data),
        .v0           (register_v0)
    );

    mips_alu alu_i (
        .exec (exec_bus.unit),
        .alu_result, .alu_writes, .branch_taken, .branch_target
    );

    mips_load_store load_store_i (
        .exec (exec_bus.unit),
        .readdata, .data_address, .data_byteenable, .data_writedata,
        .is_load, .is_store, .load_value
    );

endmodule

/* test/avalon_memory_model.sv */
`include "mips_settings.svh"

module avalon_memory_model (
    input  logic                        clk,
    input  logic [`MIPS_DATA_WIDTH-1:0] address,
    input  logic                        read,
    input  logic                        write,
    input  logic [3:0]                  byteenable,
    input  logic [`MIPS_DATA_WIDTH-1:0] writedata,
    output logic                        waitrequest,
    output logic [`MIPS_DATA_WIDTH-1:0] readdata,
    output logic [`MIPS_DATA_WIDTH-1:0] last_write_address,
    output logic [`MIPS_DATA_WIDTH-1:0] last_write_data,
    output logic [3:0]                  last_write_byteenable,
    output int                          write_count
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int word_count = 64;

    logic [`MIPS_DATA_WIDTH-1:0] words [word_count];
    integer                      seed;
    int unsigned                 wait_left;

    // Boot code lands on the low words and the data word sits further up
    function automatic int word_index(input logic [31:0] byte_address);
        return int'(byte_address[7:2]);
    endfunction

    function automatic int unsigned next_wait_count();
        return $unsigned($random(seed)) % 3;
    endfunction

    task automatic clear_memory();
        for (int i = 0; i < word_count; i++) begin
            words[i] = '0;
        end
        last_write_address    = '0;
        last_write_data       = '0;
        last_write_byteenable = 4'b0000;
        write_count           = 0;
    endtask

    task automatic load_word(input logic [31:0] byte_address, input logic [31:0] value);
        words[word_index(byte_address)] = value;
    endtask

    task automatic store_word();
        int slot;
        slot = word_index(address);
        for (int lane = 0; lane < 4; lane++) begin
            if (byteenable[lane]) begin
                words[slot][lane*8 +: 8] = writedata[lane*8 +: 8];
            end
        end
        last_write_address    = address;
        last_write_data       = writedata;
        last_write_byteenable = byteenable;
        write_count           = write_count + 1;
    endtask

    initial begin
        seed        = 32'h1bc9_375f;
        wait_left   = next_wait_count();
        waitrequest = (wait_left != 0);
        readdata    = '0;
    end

    // Wait count for the next access is drawn as the current one completes
    always @(posedge clk) begin
        if ((read || write) && !waitrequest) begin
            if (write) begin
                store_word();
            end
            wait_left = next_wait_count();
        end else if ((read || write) && wait_left != 0) begin
            wait_left = wait_left - 1;
        end
        #0.5;
        waitrequest = (wait_left != 0);
        readdata    = words[word_index(address)];
    end

endmodule

/* test/mips_cpu_bus_tb.sv */
`include "mips_settings.svh"

module mips_cpu_bus_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          clk_period   = 4;
    localparam int          row_cycles   = 60;
    // One access is at most three cycles with two wait states
    localparam int          wait_factor  = 3;
    localparam logic [31:0] data_address = 32'h0000_0080;
    localparam logic [31:0] op_a         = 32'hF000_0010;
    localparam logic [31:0] op_b         = 32'h0000_0033;
    localparam logic [31:0] mem_word     = 32'hA59C_46F1;

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] data;
        logic        tail;
        logic [31:0] v0;
        logic [31:0] writes;
    } row_t;

    logic                        clk;
    logic                        reset;
    logic                        active;
    logic [`MIPS_DATA_WIDTH-1:0] register_v0;
    logic [`MIPS_DATA_WIDTH-1:0] address;
    logic                        read;
    logic                        write;
    logic                        waitrequest;
    logic [`MIPS_DATA_WIDTH-1:0] writedata;
    logic [3:0]                  byteenable;
    logic [`MIPS_DATA_WIDTH-1:0] readdata;
    logic [`MIPS_DATA_WIDTH-1:0] last_write_address;
    logic [`MIPS_DATA_WIDTH-1:0] last_write_data;
    logic [3:0]                  last_write_byteenable;
    int                          write_count;
    row_t                        row_table[$];
    int                          error_count;
    logic                        table_ready;

    mips_cpu_bus mips_cpu_bus_i (
        .clk, .reset, .active, .register_v0, .address, .read, .write,
        .waitrequest, .writedata, .byteenable, .readdata
    );

    avalon_memory_model memory_i (
        .clk, .address, .read, .write, .byteenable, .writedata, .waitrequest, .readdata,
        .last_write_address, .last_write_data, .last_write_byteenable, .write_count
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [31:0] r_type(input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] rd, input logic [4:0] shamt,
                                           input logic [5:0] funct);
        return {6'h00, rs, rt, rd, shamt, funct};
    endfunction

    function automatic logic [31:0] i_type(input logic [5:0] opcode, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {opcode, rs, rt, imm};
    endfunction

    task automatic add_row(input logic [31:0] instr, input logic [31:0] a,
                           input logic [31:0] b, input logic [31:0] data, input logic tail,
                           input logic [31:0] v0, input logic [31:0] writes);
        row_t row;
        row.instr  = instr;
        row.a      = a;
        row.b      = b;
        row.data   = data;
        row.tail   = tail;
        row.v0     = v0;
        row.writes = writes;
        row_table.push_back(row);
    endtask

    task automatic check_value(input string name, input int index,
                               input logic [31:0] actual, input logic [31:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch %s (row %0d): got %h, expected %h", name, index, actual, expected);
        end
    endtask

    task automatic build_table();
        // ADDU SUBU AND OR XOR SLT SLTU followed by SLL SRL SRA of $4 by 4
        add_row(r_type(4, 5, 2, 0, 6'h21), op_a, op_b, mem_word, 0, 32'hF000_0043, 0);
        add_row(r_type(4, 5, 2, 0, 6'h23), op_a, op_b, mem_word, 0, 32'hEFFF_FFDD, 0);
        add_row(r_type(4, 5, 2, 0, 6'h24), op_a, op_b, mem_word, 0, 32'h0000_0010, 0);
        add_row(r_type(4, 5, 2, 0, 6'h25), op_a, op_b, mem_word, 0, 32'hF000_0033, 0);
        add_row(r_type(4, 5, 2, 0, 6'h26), op_a, op_b, mem_word, 0, 32'hF000_0023, 0);
        add_row(r_type(4, 5, 2, 0, 6'h2A), op_a, op_b, mem_word, 0, 32'h0000_0001, 0);
        add_row(r_type(4, 5, 2, 0, 6'h2B), op_a, op_b, mem_word, 0, 32'h0000_0000, 0);
        add_row(r_type(0, 4, 2, 4, 6'h00), op_a, op_b, mem_word, 0, 32'h0000_0100, 0);
        add_row(r_type(0, 4, 2, 4, 6'h02), op_a, op_b, mem_word, 0, 32'h0F00_0001, 0);
        add_row(r_type(0, 4, 2, 4, 6'h03), op_a, op_b, mem_word, 0, 32'hFF00_0001, 0);
        // ADDIU, SLTI twice, ANDI, ORI, XORI and LUI
        add_row(i_type(6'h09, 4, 2, 16'hFFF0), op_a, op_b, mem_word, 0, 32'hF000_0000, 0);
        add_row(i_type(6'h0A, 4, 2, 16'h8000), op_a, op_b, mem_word, 0, 32'h0000_0001, 0);
        add_row(i_type(6'h0A, 5, 2, 16'h8000), op_a, op_b, mem_word, 0, 32'h0000_0000, 0);
        add_row(i_type(6'h0C, 4, 2, 16'hFFFF), op_a, op_b, mem_word, 0, 32'h0000_0010, 0);
        add_row(i_type(6'h0D, 4, 2, 16'h8001), op_a, op_b, mem_word, 0, 32'hF000_8011, 0);
        add_row(i_type(6'h0E, 4, 2, 16'hFFFF), op_a, op_b, mem_word, 0, 32'hF000_FFEF, 0);
        add_row(i_type(6'h0F, 0, 2, 16'h8765), op_a, op_b, mem_word, 0, 32'h8765_0000, 0);
        // Loads based on $6 with LB and LBU per lane and LH and LHU per half
        add_row(i_type(6'h23, 6, 2, 16'h0000), op_a, op_b, mem_word, 0, 32'hA59C_46F1, 0);
        add_row(i_type(6'h20, 6, 2, 16'h0000), op_a, op_b, mem_word, 0, 32'hFFFF_FFF1, 0);
        add_row(i_type(6'h20, 6, 2, 16'h0001), op_a, op_b, mem_word, 0, 32'h0000_0046, 0);
        add_row(i_type(6'h20, 6, 2, 16'h0002), op_a, op_b, mem_word, 0, 32'hFFFF_FF9C, 0);
        add_row(i_type(6'h20, 6, 2, 16'h0003), op_a, op_b, mem_word, 0, 32'hFFFF_FFA5, 0);
        add_row(i_type(6'h24, 6, 2, 16'h0000), op_a, op_b, mem_word, 0, 32'h0000_00F1, 0);
        add_row(i_type(6'h24, 6, 2, 16'h0001), op_a, op_b, mem_word, 0, 32'h0000_0046, 0);
        add_row(i_type(6'h24, 6, 2, 16'h0002), op_a, op_b, mem_word, 0, 32'h0000_009C, 0);
        add_row(i_type(6'h24, 6, 2, 16'h0003), op_a, op_b, mem_word, 0, 32'h0000_00A5, 0);
        add_row(i_type(6'h21, 6, 2, 16'h0000), op_a, op_b, mem_word, 0, 32'h0000_46F1, 0);
        add_row(i_type(6'h21, 6, 2, 16'h0002), op_a, op_b, mem_word, 0, 32'hFFFF_A59C, 0);
        add_row(i_type(6'h25, 6, 2, 16'h0000), op_a, op_b, mem_word, 0, 32'h0000_46F1, 0);
        add_row(i_type(6'h25, 6, 2, 16'h0002), op_a, op_b, mem_word, 0, 32'h0000_A59C, 0);
        // SW of $5 leaves $v0 alone
        add_row(i_type(6'h2B, 6, 5, 16'h0000), op_a, op_b, mem_word, 0, 32'h0000_0000, 1);
        // A taken branch gives 1 from the delay slot alone and an untaken one runs both ADDIUs
        add_row(i_type(6'h04, 4, 5, 16'h0002), op_a, op_b, mem_word, 1, 32'h0000_0011, 0);
        add_row(i_type(6'h04, 4, 4, 16'h0002), op_a, op_b, mem_word, 1, 32'h0000_0001, 0);
        add_row(i_type(6'h05, 4, 5, 16'h0002), op_a, op_b, mem_word, 1, 32'h0000_0001, 0);
        add_row(i_type(6'h05, 5, 5, 16'h0002), op_a, op_b, mem_word, 1, 32'h0000_0011, 0);
        // J straight to the JR word at BFC00024
        add_row({6'h02, 26'h3F0_0009}, op_a, op_b, mem_word, 1, 32'h0000_0001, 0);
    endtask

    task automatic load_program(input row_t row);
        logic [31:0] program_words [11];
        memory_i.clear_memory();
        memory_i.load_word(data_address, row.data);
        program_words[0]  = i_type(6'h0F, 0, 4, row.a[31:16]);
        program_words[1]  = i_type(6'h0D, 4, 4, row.a[15:0]);
        program_words[2]  = i_type(6'h0F, 0, 5, row.b[31:16]);
        program_words[3]  = i_type(6'h0D, 5, 5, row.b[15:0]);
        program_words[4]  = i_type(6'h0F, 0, 6, data_address[31:16]);
        program_words[5]  = i_type(6'h0D, 6, 6, data_address[15:0]);
        program_words[6]  = row.instr;
        // Delay slot and the word a taken branch skips
        program_words[7]  = row.tail ? i_type(6'h09, 2, 2, 16'h0001) : 32'h0;
        program_words[8]  = row.tail ? i_type(6'h09, 2, 2, 16'h0010) : 32'h0;
        program_words[9]  = r_type(0, 0, 0, 0, 6'h08);
        program_words[10] = 32'h0;
        for (int i = 0; i < 11; i++) begin
            memory_i.load_word(`MIPS_RESET_VECTOR + 4 * i, program_words[i]);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #0.5 reset = 1'b1;
        repeat (2) @(posedge clk);
        #0.5 reset = 1'b0;
    endtask

    task automatic run_row(input int index, input row_t row);
        load_program(row);
        apply_reset();
        @(negedge clk);
        while (active !== 1'b0) begin
            @(negedge clk);
        end
        check_value("register_v0", index, register_v0, row.v0);
        check_value("write_count", index, write_count, row.writes);
        if (row.writes != 0) begin
            check_value("last_write_address", index, last_write_address, data_address);
            check_value("last_write_data", index, last_write_data, row.b);
            check_value("last_write_byteenable", index, last_write_byteenable, 4'b1111);
        end
        // HALTED keeps the bus idle
        repeat (6) begin
            @(negedge clk);
            check_value("read", index, read, 1'b0);
            check_value("write", index, write, 1'b0);
            check_value("active", index, active, 1'b0);
        end
    endtask

    initial begin
        reset       = 1'b1;
        error_count = 0;
        table_ready = 1'b0;
        build_table();
        table_ready = 1'b1;
        for (int i = 0; i < row_table.size(); i++) begin
            run_row(i, row_table[i]);
        end
        $display("Errors: %0d", error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin : watchdog
        int limit_ns;
        wait (table_ready);
        limit_ns = row_table.size() * row_cycles * wait_factor * clk_period;
        #(limit_ns);
        $display("Timeout: the test rows did not finish within %0d ns", limit_ns);
        $display("Errors: %0d", error_count);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* sources.f */
+incdir+source
source/mips_pkg.sv
source/mips_exec_if.sv
source/mips_register_file.sv
source/mips_alu.sv
source/mips_load_store.sv
source/mips_core_control.sv
source/mips_cpu_bus.sv
test/avalon_memory_model.sv
test/mips_cpu_bus_tb.sv

/* Bender.yml */
package:
  name: mips_cpu_bus

sources:
  - include_dirs:
      - source
    files:
      - source/mips_pkg.sv
      - source/mips_exec_if.sv
      - source/mips_register_file.sv
      - source/mips_alu.sv
      - source/mips_load_store.sv
      - source/mips_core_control.sv
      - source/mips_cpu_bus.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/avalon_memory_model.sv
      - test/mips_cpu_bus_tb.sv
